//--- hw/sys_pkg.sv
`default_nettype none

package sys_pkg;

    // processor address and cache geometry
    localparam int xlen        = 32;
    localparam int block_bytes = 8;
    localparam int block_bits  = block_bytes * 8;          // one 64-bit block per line
    localparam int offset_bits = $clog2(block_bytes);      // 3
    localparam int cache_lines = 16;
    localparam int index_bits  = $clog2(cache_lines);      // 4
    localparam int tag_bits    = xlen - index_bits - offset_bits;  // 25

    // memory bus tags, tag 0 means no tag
    localparam int num_tags     = 16;
    localparam int mem_tag_bits = $clog2(num_tags);

    // memory bus commands
    localparam logic [1:0] bus_none  = 2'b00;
    localparam logic [1:0] bus_load  = 2'b01;
    localparam logic [1:0] bus_store = 2'b10;

    // who owns an outstanding memory tag
    localparam logic [1:0] owner_none   = 2'b00;
    localparam logic [1:0] owner_icache = 2'b01;
    localparam logic [1:0] owner_dcache = 2'b10;

    // icache miss FSM
    localparam logic [1:0] ic_idle    = 2'b00;
    localparam logic [1:0] ic_request = 2'b01;
    localparam logic [1:0] ic_wait    = 2'b10;

    // dcache operation FSM
    localparam logic [1:0] dc_idle    = 2'b00;
    localparam logic [1:0] dc_request = 2'b01;
    localparam logic [1:0] dc_wait    = 2'b10;
    localparam logic [1:0] dc_done    = 2'b11;

endpackage

`default_nettype wire

//--- hw/mem_controller.sv
`timescale 1ns/100ps
`default_nettype none

module mem_controller import sys_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    // instruction cache request
    input  logic [1:0]              icache_command,
    input  logic [xlen-1:0]         icache_addr,

    // data cache request
    input  logic [1:0]              dcache_command,
    input  logic [xlen-1:0]         dcache_addr,
    input  logic [block_bits-1:0]   dcache_data,

    // accepted tag, only the granted cache sees it
    output logic [mem_tag_bits-1:0] icache_response,
    output logic [mem_tag_bits-1:0] dcache_response,

    // memory bus
    output logic [1:0]              proc2mem_command,
    output logic [xlen-1:0]         proc2mem_addr,
    output logic [block_bits-1:0]   proc2mem_data,
    input  logic [mem_tag_bits-1:0] mem2proc_response,
    input  logic [block_bits-1:0]   mem2proc_data,
    input  logic [mem_tag_bits-1:0] mem2proc_tag,

    // fill path, data goes to both caches
    output logic [block_bits-1:0]   cache_data,
    output logic                    icache_fill,
    output logic                    dcache_fill
);

    logic [1:0] owner_table [num_tags];  // indexed by memory tag

    logic       dcache_selected;
    logic       icache_selected;
    logic       accepted;
    logic       load_accepted;
    logic [1:0] grant_owner;
    logic       data_returned;
    logic [1:0] response_owner;

    // data cache has priority whenever it asks for anything
    assign dcache_selected = (dcache_command != bus_none);
    assign icache_selected = !dcache_selected && (icache_command != bus_none);

    always_comb begin
        if (dcache_selected) begin
            proc2mem_command = dcache_command;
            proc2mem_addr    = dcache_addr;
        end else begin
            proc2mem_command = icache_command;
            proc2mem_addr    = icache_addr;
        end
    end

    assign proc2mem_data = dcache_data;  // only stores carry data, and only dcache stores

    assign accepted        = (mem2proc_response != '0);
    assign dcache_response = dcache_selected ? mem2proc_response : '0;
    assign icache_response = icache_selected ? mem2proc_response : '0;

    // stores return no data so their tags are never recorded
    assign load_accepted = accepted && (proc2mem_command == bus_load);
    assign grant_owner   = dcache_selected ? owner_dcache : owner_icache;

    // steer returning block to whoever asked for it
    assign data_returned  = (mem2proc_tag != '0);
    assign response_owner = owner_table[mem2proc_tag];
    assign cache_data     = mem2proc_data;
    assign icache_fill    = data_returned && (response_owner == owner_icache);
    assign dcache_fill    = data_returned && (response_owner == owner_dcache);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < num_tags; i++) begin
                owner_table[i] <= owner_none;
            end
        end else begin
            if (data_returned) begin
                owner_table[mem2proc_tag] <= owner_none;  // tag freed
            end
            // a tag freed this cycle may be handed out again at once
            if (load_accepted) begin
                owner_table[mem2proc_response] <= grant_owner;
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/icache.sv
`timescale 1ns/100ps
`default_nettype none

module icache import sys_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    // fetch side
    input  logic                    fetch_valid,
    input  logic [xlen-1:0]         fetch_addr,
    output logic [block_bits-1:0]   fetch_data,
    output logic                    fetch_hit,

    // to the memory controller
    output logic [1:0]              icache_command,
    output logic [xlen-1:0]         icache_addr,
    input  logic [mem_tag_bits-1:0] icache_response,

    // fill path
    input  logic [block_bits-1:0]   cache_data,
    input  logic                    icache_fill
);

    logic [tag_bits-1:0]   tag_array  [cache_lines];
    logic [block_bits-1:0] data_array [cache_lines];
    logic [cache_lines-1:0] valid_array;

    logic [index_bits-1:0] fetch_index;
    logic [tag_bits-1:0]   fetch_tag;

    logic [1:0]            state;
    logic [1:0]            next_state;
    logic [xlen-1:0]       miss_addr;   // block aligned
    logic [index_bits-1:0] miss_index;
    logic [tag_bits-1:0]   miss_tag;
    logic                  start_miss;

    assign fetch_index = fetch_addr[offset_bits +: index_bits];
    assign fetch_tag   = fetch_addr[xlen-1 -: tag_bits];

    // lookup is purely combinational
    assign fetch_hit  = fetch_valid && valid_array[fetch_index]
                        && (tag_array[fetch_index] == fetch_tag);
    assign fetch_data = data_array[fetch_index];

    assign miss_index = miss_addr[offset_bits +: index_bits];
    assign miss_tag   = miss_addr[xlen-1 -: tag_bits];
    assign start_miss = (state == ic_idle) && fetch_valid && !fetch_hit;

    // load is held until the memory hands back a tag
    assign icache_command = (state == ic_request) ? bus_load : bus_none;
    assign icache_addr    = miss_addr;

    always_comb begin
        next_state = state;
        case (state)
            ic_idle: begin
                if (start_miss) begin
                    next_state = ic_request;
                end
            end
            ic_request: begin
                if (icache_response != '0) begin
                    next_state = ic_wait;
                end
            end
            ic_wait: begin
                if (icache_fill) begin
                    next_state = ic_idle;  // line valid from next cycle
                end
            end
            default: next_state = ic_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= ic_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (start_miss) begin
            miss_addr <= {fetch_addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            valid_array <= '0;
        end else if ((state == ic_wait) && icache_fill) begin
            valid_array[miss_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if ((state == ic_wait) && icache_fill) begin
            tag_array[miss_index]  <= miss_tag;
            data_array[miss_index] <= cache_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/dcache.sv
`timescale 1ns/100ps
`default_nettype none

module dcache import sys_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    // processor side, command held until dmem_done
    input  logic [1:0]              dmem_command,
    input  logic [xlen-1:0]         dmem_addr,
    input  logic [block_bits-1:0]   dmem_store_data,
    output logic [block_bits-1:0]   dmem_load_data,
    output logic                    dmem_done,

    // to the memory controller
    output logic [1:0]              dcache_command,
    output logic [xlen-1:0]         dcache_addr,
    output logic [block_bits-1:0]   dcache_data,
    input  logic [mem_tag_bits-1:0] dcache_response,

    // fill path
    input  logic [block_bits-1:0]   cache_data,
    input  logic                    dcache_fill
);

    logic [tag_bits-1:0]   tag_array  [cache_lines];
    logic [block_bits-1:0] data_array [cache_lines];
    logic [cache_lines-1:0] valid_array;

    logic [index_bits-1:0] dmem_index;
    logic [tag_bits-1:0]   dmem_tag;
    logic                  lookup_hit;

    logic [1:0]            state;
    logic [1:0]            next_state;
    logic [1:0]            req_command;  // operation in flight
    logic [xlen-1:0]       req_addr;
    logic [block_bits-1:0] req_data;
    logic [index_bits-1:0] req_index;
    logic [tag_bits-1:0]   req_tag;

    logic                  sample;
    logic                  store_hit;
    logic                  line_fill;

    assign dmem_index = dmem_addr[offset_bits +: index_bits];
    assign dmem_tag   = dmem_addr[xlen-1 -: tag_bits];
    assign lookup_hit = valid_array[dmem_index] && (tag_array[dmem_index] == dmem_tag);

    assign req_index = req_addr[offset_bits +: index_bits];
    assign req_tag   = req_addr[xlen-1 -: tag_bits];

    // new commands are only taken while idle
    assign sample    = (state == dc_idle) && (dmem_command != bus_none);
    assign store_hit = (state == dc_idle) && (dmem_command == bus_store) && lookup_hit;
    assign line_fill = (state == dc_wait) && dcache_fill;

    assign dcache_command = (state == dc_request) ? req_command : bus_none;
    assign dcache_addr    = {req_addr[xlen-1:offset_bits], {offset_bits{1'b0}}};
    assign dcache_data    = req_data;

    assign dmem_load_data = data_array[req_index];
    assign dmem_done      = (state == dc_done);

    always_comb begin
        next_state = state;
        case (state)
            dc_idle: begin
                if (dmem_command == bus_load) begin
                    next_state = lookup_hit ? dc_done : dc_request;
                end else if (dmem_command == bus_store) begin
                    next_state = dc_request;  // write through, hit or miss
                end
            end
            dc_request: begin
                if (dcache_response != '0) begin
                    next_state = (req_command == bus_store) ? dc_done : dc_wait;
                end
            end
            dc_wait: begin
                if (dcache_fill) begin
                    next_state = dc_done;
                end
            end
            dc_done: next_state = dc_idle;
            default: next_state = dc_idle;
        endcase
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= dc_idle;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clock) begin
        if (sample) begin
            req_command <= dmem_command;
            req_addr    <= dmem_addr;
            req_data    <= dmem_store_data;
        end
    end

    // load misses allocate, store misses do not
    always_ff @(posedge clock) begin
        if (reset) begin
            valid_array <= '0;
        end else if (line_fill) begin
            valid_array[req_index] <= 1'b1;
        end
    end

    always_ff @(posedge clock) begin
        if (line_fill) begin
            tag_array[req_index]  <= req_tag;
            data_array[req_index] <= cache_data;
        end else if (store_hit) begin
            data_array[dmem_index] <= dmem_store_data;  // keep line in step with memory
        end
    end

endmodule

`default_nettype wire

//--- hw/memsys_top.sv
`timescale 1ns/100ps
`default_nettype none

module memsys_top import sys_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,

    // instruction fetch
    input  logic                    fetch_valid,
    input  logic [xlen-1:0]         fetch_addr,
    output logic [block_bits-1:0]   fetch_data,
    output logic                    fetch_hit,

    // data access
    input  logic [1:0]              dmem_command,
    input  logic [xlen-1:0]         dmem_addr,
    input  logic [block_bits-1:0]   dmem_store_data,
    output logic [block_bits-1:0]   dmem_load_data,
    output logic                    dmem_done,

    // memory bus
    output logic [1:0]              proc2mem_command,
    output logic [xlen-1:0]         proc2mem_addr,
    output logic [block_bits-1:0]   proc2mem_data,
    input  logic [mem_tag_bits-1:0] mem2proc_response,
    input  logic [block_bits-1:0]   mem2proc_data,
    input  logic [mem_tag_bits-1:0] mem2proc_tag
);

    logic [1:0]              icache_command;
    logic [xlen-1:0]         icache_addr;
    logic [mem_tag_bits-1:0] icache_response;
    logic [1:0]              dcache_command;
    logic [xlen-1:0]         dcache_addr;
    logic [block_bits-1:0]   dcache_data;
    logic [mem_tag_bits-1:0] dcache_response;
    logic [block_bits-1:0]   cache_data;   // shared fill bus
    logic                    icache_fill;
    logic                    dcache_fill;

    icache i_icache (
        .clock, .reset,
        .fetch_valid, .fetch_addr, .fetch_data, .fetch_hit,
        .icache_command, .icache_addr, .icache_response,
        .cache_data, .icache_fill
    );

    dcache i_dcache (
        .clock, .reset,
        .dmem_command, .dmem_addr, .dmem_store_data, .dmem_load_data, .dmem_done,
        .dcache_command, .dcache_addr, .dcache_data, .dcache_response,
        .cache_data, .dcache_fill
    );

    mem_controller i_mem_controller (
        .clock, .reset,
        .icache_command, .icache_addr,
        .dcache_command, .dcache_addr, .dcache_data,
        .icache_response, .dcache_response,
        .proc2mem_command, .proc2mem_addr, .proc2mem_data,
        .mem2proc_response, .mem2proc_data, .mem2proc_tag,
        .cache_data, .icache_fill, .dcache_fill
    );

endmodule

`default_nettype wire

//--- dv/mem_model.sv
`timescale 1ns/100ps
`default_nettype none

module mem_model import sys_pkg::*; (
    input  logic                    clock,
    input  logic                    reset,
    input  logic [31:0]             random_bits,   // new each cycle from the testbench
    input  logic [1:0]              proc2mem_command,
    input  logic [xlen-1:0]         proc2mem_addr,
    input  logic [block_bits-1:0]   proc2mem_data,
    output logic [mem_tag_bits-1:0] mem2proc_response,
    output logic [block_bits-1:0]   mem2proc_data,
    output logic [mem_tag_bits-1:0] mem2proc_tag
);

    logic [block_bits-1:0]   mem [1024];              // 8 KB, word index is addr[12:3]
    logic [block_bits-1:0]   pending_data [num_tags];
    int                      due_cycle [num_tags];
    logic [num_tags-1:0]     busy;                    // load tags still owed their data
    int                      cycle;
    logic                    refuse;
    logic [mem_tag_bits-1:0] candidate;
    logic [mem_tag_bits-1:0] free_tag;
    logic                    sent;

    function automatic logic [block_bits-1:0] address_pattern(input logic [31:0] addr);
        logic [31:0] mixed;
        mixed = (addr ^ 32'h5bd1e995) * 32'h9e3779b1;
        return {mixed ^ {addr[15:0], addr[31:16]}, ~addr ^ (mixed >> 7)};
    endfunction

    initial begin
        for (int i = 0; i < 1024; i++) begin
            mem[i] = address_pattern(i * 8);
        end
    end

    assign refuse = (random_bits[9:0] < 10'd307);  // about 30 percent

    // first free tag at or after a random start, tag 0 is never handed out
    always_comb begin
        free_tag  = '0;
        candidate = '0;
        for (int k = num_tags - 1; k >= 0; k--) begin
            candidate = mem_tag_bits'(random_bits[13:10] + k);
            if (candidate != '0 && !busy[candidate]) begin
                free_tag = candidate;
            end
        end
    end

    // acceptance is decided in the same cycle the request is seen
    assign mem2proc_response = (!reset && proc2mem_command != bus_none && !refuse)
                               ? free_tag : '0;

    always @(posedge clock) begin
        if (reset) begin
            busy          <= '0;
            cycle         <= 0;
            mem2proc_tag  <= '0;
            mem2proc_data <= '0;
        end else begin
            cycle        <= cycle + 1;
            mem2proc_tag <= '0;
            sent = 1'b0;
            for (int t = 1; t < num_tags; t++) begin
                if (!sent && busy[t] && due_cycle[t] <= cycle) begin
                    mem2proc_tag  <= mem_tag_bits'(t);  // one response per cycle
                    mem2proc_data <= pending_data[t];
                    busy[t]       <= 1'b0;
                    sent = 1'b1;
                end
            end
            if (mem2proc_response != '0 && proc2mem_command == bus_load) begin
                busy[mem2proc_response]         <= 1'b1;
                due_cycle[mem2proc_response]    <= cycle + 1 + random_bits[16:14];
                pending_data[mem2proc_response] <= mem[proc2mem_addr[12:3]];
            end else if (mem2proc_response != '0) begin
                mem[proc2mem_addr[12:3]] = proc2mem_data;  // store, tag but no data
            end
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_memsys.sv
`timescale 1ns/100ps
`default_nettype none

module tb_memsys import sys_pkg::*; ();

    logic                    clock;
    logic                    reset;
    logic                    fetch_valid;
    logic                    fetch_hit;
    logic [xlen-1:0]         fetch_addr;
    logic [block_bits-1:0]   fetch_data;
    logic [1:0]              dmem_command;
    logic                    dmem_done;
    logic [xlen-1:0]         dmem_addr;
    logic [block_bits-1:0]   dmem_store_data;
    logic [block_bits-1:0]   dmem_load_data;
    logic [1:0]              proc2mem_command;
    logic [xlen-1:0]         proc2mem_addr;
    logic [block_bits-1:0]   proc2mem_data;
    logic [block_bits-1:0]   mem2proc_data;
    logic [mem_tag_bits-1:0] mem2proc_response;
    logic [mem_tag_bits-1:0] mem2proc_tag;
    logic [31:0]             random_bits;          // acceptance, tag and latency choices

    logic [31:0]             stim_state;
    logic [31:0]             mem_state;
    logic [block_bits-1:0]   shadow_mem [1024];    // indexed by addr[12:3]
    logic [1023:0]           shadow_written;
    logic                    done_last;
    int                      checks;
    int                      errors;
    int                      test_checks;
    int                      test_errors;
    int                      wait_cycles;          // cycles the last issue took

    memsys_top i_dut (.*);
    mem_model  i_mem (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        return y ^ (y << 5);
    endfunction

    // initial memory content mixes the doubleword's address
    function automatic logic [block_bits-1:0] fill_pattern(input logic [31:0] addr);
        logic [31:0] mixed;
        mixed = (addr ^ 32'h5bd1e995) * 32'h9e3779b1;
        return {mixed ^ {addr[15:0], addr[31:16]}, ~addr ^ (mixed >> 7)};
    endfunction

    // expected doubleword for any byte address
    function automatic logic [block_bits-1:0] expected_word(input logic [xlen-1:0] addr);
        if (shadow_written[addr[12:3]]) begin
            return shadow_mem[addr[12:3]];
        end
        return fill_pattern({addr[31:3], 3'b000});
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s did not finish within 200 cycles", what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    task automatic end_test(input string name);
        $display("test %s: %0d checks, %0d errors", name,
                 checks - test_checks, errors - test_errors);
        test_checks = checks;
        test_errors = errors;
    endtask

    // fetch and data access run side by side until both have finished
    task automatic issue(input bit fetch_on, input logic [xlen-1:0] code_addr,
                         input logic [1:0] command, input logic [xlen-1:0] data_addr,
                         input logic [block_bits-1:0] value);
        bit fetch_seen;
        bit data_seen;
        fetch_seen  = !fetch_on;
        data_seen   = (command == bus_none);
        wait_cycles = 0;
        @(posedge clock);
        #10;
        fetch_valid     = fetch_on;
        fetch_addr      = code_addr;
        dmem_command    = command;
        dmem_addr       = data_addr;
        dmem_store_data = value;
        while (wait_cycles < 200 && !(fetch_seen && data_seen)) begin
            @(posedge clock);
            wait_cycles++;
            fetch_seen = fetch_seen || fetch_hit;
            data_seen  = data_seen || dmem_done;
            #10;
            if (fetch_seen) fetch_valid = 1'b0;
            if (data_seen) dmem_command = bus_none;
        end
        assert (fetch_seen && data_seen) else
            abort_on_timeout($sformatf("access to %h / %h", code_addr, data_addr));
    endtask

    task automatic check_memory(input logic [xlen-1:0] addr);
        checks++;
        assert (i_mem.mem[addr[12:3]] == expected_word(addr)) else begin
            errors++;
            $display("mismatch i_mem.mem at %h: got %h, expected %h",
                     addr, i_mem.mem[addr[12:3]], expected_word(addr));
        end
    endtask

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    always @(posedge clock) begin
        #10;
        mem_state   = xorshift(mem_state);
        random_bits = mem_state;
    end

    // checks every fetch hit and every dmem_done
    always @(posedge clock) begin
        if (!reset && fetch_hit) begin
            checks++;
            assert (fetch_data == expected_word(fetch_addr)) else begin
                errors++;
                $display("mismatch fetch_data at %h: got %h, expected %h",
                         fetch_addr, fetch_data, expected_word(fetch_addr));
            end
        end
        if (!reset && dmem_done) begin
            checks++;
            assert (!done_last) else begin
                errors++;
                $display("dmem_done stayed high for more than one cycle");
            end
            if (dmem_command == bus_load) begin
                checks++;
                assert (dmem_load_data == expected_word(dmem_addr)) else begin
                    errors++;
                    $display("mismatch dmem_load_data at %h: got %h, expected %h",
                             dmem_addr, dmem_load_data, expected_word(dmem_addr));
                end
            end else begin
                shadow_mem[dmem_addr[12:3]]     = dmem_store_data;  // store completed
                shadow_written[dmem_addr[12:3]] = 1'b1;
            end
        end
        done_last = dmem_done;
    end

    initial begin
        logic [xlen-1:0]       code_addr;
        logic [xlen-1:0]       data_addr;
        logic [block_bits-1:0] value;
        logic [1:0]            command;

        reset           = 1'b1;
        fetch_valid     = 1'b0;
        fetch_addr      = '0;
        dmem_command    = bus_none;
        dmem_addr       = '0;
        dmem_store_data = '0;
        random_bits     = '0;
        stim_state      = 32'h57de;
        mem_state       = ~stim_state;  // separate stream for the memory
        shadow_written  = '0;
        done_last       = 1'b0;
        checks          = 0;
        errors          = 0;
        test_checks     = 0;
        test_errors     = 0;
        repeat (3) @(posedge clock);
        #10;
        reset = 1'b0;

        issue(1'b1, 32'h0000_0040, bus_none, '0, '0);  // cold miss
        issue(1'b1, 32'h0000_0044, bus_none, '0, '0);
        checks++;
        assert (wait_cycles == 1) else begin
            errors++;
            $display("second fetch to a cached block did not hit in its first cycle");
        end
        end_test("1 instruction fetch");

        issue(1'b0, '0, bus_load, 32'h0000_1080, '0);
        issue(1'b0, '0, bus_load, 32'h0000_1084, '0);
        checks++;
        assert (wait_cycles == 2) else begin
            errors++;
            $display("second load to a cached block did not hit");
        end
        end_test("2 data load");

        // cached block first, then a block never loaded
        issue(1'b0, '0, bus_store, 32'h0000_1080, 64'h0123_4567_89ab_cdef);
        issue(1'b0, '0, bus_load, 32'h0000_1080, '0);
        issue(1'b0, '0, bus_store, 32'h0000_1200, 64'hfedc_ba98_7654_3210);
        issue(1'b0, '0, bus_load, 32'h0000_1200, '0);
        check_memory(32'h0000_1080);
        check_memory(32'h0000_1200);
        end_test("3 stores");

        for (int i = 0; i < 8; i++) begin
            issue(1'b1, 32'h0000_0100 + i * 8, bus_load, 32'h0000_1100 + i * 8, '0);
        end
        end_test("4 concurrent fetch and load");

        // code in 0x000 to 0x3ff and data in 0x1000 to 0x13ff map onto the same indices
        for (int i = 0; i < 300; i++) begin
            stim_state = xorshift(stim_state);
            code_addr  = {22'h0, stim_state[9:0]};
            data_addr  = {22'h4, stim_state[25:16]};
            command    = (stim_state[31:30] == 2'b00) ? bus_store : bus_load;
            stim_state = xorshift(stim_state);
            value      = {stim_state, ~stim_state ^ code_addr};
            issue(1'b1, code_addr, command, data_addr, value);
        end
        end_test("5 random mixed stream");

        $display("tests 5, checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
hw/sys_pkg.sv
hw/mem_controller.sv
hw/icache.sv
hw/dcache.sv
hw/memsys_top.sv
dv/mem_model.sv
dv/tb_memsys.sv
